/* logic/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ARCH_REGS     = 32;
    localparam int PHYS_REGS     = 64;
    localparam int AREG_W        = 5;
    localparam int PREG_W        = 6;
    localparam int IMM_W         = 32;
    localparam int PC_W          = 30;
    localparam int PACK_W        = 4;
    localparam int RENAME_WIDTH  = 2;
    localparam int FREE_AT_RESET = PHYS_REGS - ARCH_REGS;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        SKID_EMPTY = 2'd0,
        SKID_ONE   = 2'd1,
        SKID_TWO   = 2'd2
    } skid_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Packets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic              valid;
        alu_op_e           opcode;
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
        logic [AREG_W-1:0] rd;
        logic              uses_imm;
        logic [IMM_W-1:0]  imm;
        logic              writes_rd;
    } uop_t;

    typedef struct packed {
        uop_t [RENAME_WIDTH-1:0] uop;
        logic [PC_W-1:0]         pc;
    } bundle_t;

    typedef struct packed {
        logic              valid;
        alu_op_e           opcode;
        logic [PREG_W-1:0] prs1;
        logic [PREG_W-1:0] prs2;
        logic [PREG_W-1:0] prd;
        logic              uses_imm;
        logic [IMM_W-1:0]  imm;
        logic [PACK_W:0]   rob_id;   // Pack, then slot bit
    } dispatch_t;

    typedef struct packed {
        logic              valid;
        logic              allocated;
        logic [AREG_W-1:0] arch_rd;
        logic [PREG_W-1:0] old_prd;
        logic [PREG_W-1:0] new_prd;
    } retire_t;

    typedef struct packed {
        logic              valid;
        logic              allocated;
        logic [AREG_W-1:0] arch_rd;
        logic [PREG_W-1:0] new_prd;
        logic [PREG_W-1:0] old_prd;
    } commit_t;

endpackage

`default_nettype wire

/* logic/rename_skid.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_skid import rename_pkg::*; (
    input  wire logic    cpu_clock_i,
    input  wire logic    arst_n_i,
    input  wire bundle_t bundle_i,
    input  wire logic    valid_i,
    output logic         busy_o,
    input  wire logic    recovery_i,
    output bundle_t      head_o,
    output logic         head_valid_o,
    input  wire logic    take_i
);

    skid_state_e state_q;
    skid_state_e state_d;
    bundle_t     head_q;
    bundle_t     spare_q;   // Second entry, filled only behind a stalled head
    logic        accept;
    logic        take;

    assign accept = valid_i & ~busy_o;
    assign take   = take_i & head_valid_o;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            SKID_EMPTY: if (accept) state_d = SKID_ONE;
            SKID_ONE: begin
                if (accept && !take) state_d = SKID_TWO;
                else if (!accept && take) state_d = SKID_EMPTY;
            end
            SKID_TWO:   if (take) state_d = SKID_ONE;
            default:    state_d = SKID_EMPTY;
        endcase
        if (recovery_i) state_d = SKID_EMPTY;
    end

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= SKID_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (state_q == SKID_TWO) begin
            if (take) head_q <= spare_q;   // Spare moves up
        end else if (accept && (state_q == SKID_EMPTY || take)) begin
            head_q <= bundle_i;
        end
        if (accept && state_q == SKID_ONE && !take) begin
            spare_q <= bundle_i;
        end
    end

    assign head_o       = head_q;
    assign head_valid_o = (state_q != SKID_EMPTY);
    assign busy_o       = (state_q == SKID_TWO);

endmodule

`default_nettype wire

/* logic/spec_map_table.sv */
`timescale 1ns/1ps
`default_nettype none

module spec_map_table import rename_pkg::*; (
    input  wire logic                                  cpu_clock_i,
    input  wire logic                                  arst_n_i,
    input  wire logic [3*RENAME_WIDTH-1:0][AREG_W-1:0] rd_areg_i,
    output logic      [3*RENAME_WIDTH-1:0][PREG_W-1:0] rd_preg_o,
    input  wire logic [RENAME_WIDTH-1:0]               wr_en_i,
    input  wire logic [RENAME_WIDTH-1:0][AREG_W-1:0]   wr_areg_i,
    input  wire logic [RENAME_WIDTH-1:0][PREG_W-1:0]   wr_preg_i,
    input  wire commit_t [RENAME_WIDTH-1:0]            commit_i,
    input  wire logic                                  recovery_i
);

    logic [PREG_W-1:0] spec_map     [ARCH_REGS];
    logic [PREG_W-1:0] commit_map   [ARCH_REGS];
    logic [PREG_W-1:0] commit_map_d [ARCH_REGS];

    // Read ports straight off the speculative map
    always_comb begin
        for (int i = 0; i < 3*RENAME_WIDTH; i++) begin
            rd_preg_o[i] = spec_map[rd_areg_i[i]];
        end
    end

    // Committed map after this cycle's commits, later slot last
    always_comb begin
        commit_map_d = commit_map;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            if (commit_i[s].valid && commit_i[s].allocated) begin
                commit_map_d[commit_i[s].arch_rd] = commit_i[s].new_prd;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Map update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                spec_map[r]   <= PREG_W'(r);
                commit_map[r] <= PREG_W'(r);
            end
        end else begin
            commit_map <= commit_map_d;
            if (recovery_i) begin
                spec_map <= commit_map_d;   // Includes same-cycle commits
            end else begin
                for (int s = 0; s < RENAME_WIDTH; s++) begin
                    // Slot 1 issued later so it overrides slot 0
                    if (wr_en_i[s]) spec_map[wr_areg_i[s]] <= wr_preg_i[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list import rename_pkg::*; (
    input  wire logic                                cpu_clock_i,
    input  wire logic                                arst_n_i,
    input  wire logic [RENAME_WIDTH-1:0]             pop_i,
    output logic      [RENAME_WIDTH-1:0][PREG_W-1:0] pop_preg_o,
    output logic      [PREG_W-1:0]                   avail_o,
    input  wire commit_t [RENAME_WIDTH-1:0]          commit_i,
    input  wire logic                                recovery_i
);

    logic [PREG_W-1:0]       fl_mem [PHYS_REGS];
    logic [PREG_W-1:0]       head_q;    // Speculative head
    logic [PREG_W-1:0]       chead_q;   // Committed head
    logic [PREG_W-1:0]       tail_q;
    logic [PREG_W-1:0]       head_nx1;
    logic [PREG_W-1:0]       chead_d;
    logic [PREG_W-1:0]       tail_d;
    logic [RENAME_WIDTH-1:0] push;
    logic [1:0]              n_push;
    logic [1:0]              n_pop;

    always_comb begin
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            push[s] = commit_i[s].valid & commit_i[s].allocated;
        end
    end

    assign n_push = 2'(push[0]) + 2'(push[1]);
    assign n_pop  = 2'(pop_i[0]) + 2'(pop_i[1]);

    assign head_nx1 = head_q + PREG_W'(1);
    assign chead_d  = chead_q + PREG_W'(n_push);
    assign tail_d   = tail_q + PREG_W'(n_push);

    // Slot 1 takes the second entry only when slot 0 also pops
    assign pop_preg_o[0] = fl_mem[head_q];
    assign pop_preg_o[1] = pop_i[0] ? fl_mem[head_nx1] : fl_mem[head_q];

    assign avail_o = tail_q - head_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage and pointers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                fl_mem[i] <= PREG_W'(ARCH_REGS + i);   // Above ARCH_REGS ascending
            end
        end else begin
            if (push[0]) fl_mem[tail_q] <= commit_i[0].old_prd;
            if (push[1]) fl_mem[tail_q + PREG_W'(push[0])] <= commit_i[1].old_prd;
        end
    end

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            chead_q <= '0;
            tail_q  <= PREG_W'(FREE_AT_RESET);
        end else begin
            chead_q <= chead_d;
            tail_q  <= tail_d;
            // Rewind works because allocation order equals commit order
            if (recovery_i) head_q <= chead_d;
            else head_q <= head_q + PREG_W'(n_pop);
        end
    end

endmodule

`default_nettype wire

/* logic/rename_bundle.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_bundle import rename_pkg::*; (
    input  wire bundle_t                               head_i,
    input  wire logic [3*RENAME_WIDTH-1:0][PREG_W-1:0] src_preg_i,
    input  wire logic [RENAME_WIDTH-1:0][PREG_W-1:0]   new_preg_i,
    input  wire logic [PACK_W-1:0]                     rob_pack_i,
    output logic      [3*RENAME_WIDTH-1:0][AREG_W-1:0] rd_areg_o,
    output logic      [RENAME_WIDTH-1:0]               alloc_o,
    output dispatch_t [RENAME_WIDTH-1:0]               dispatch_o,
    output retire_t   [RENAME_WIDTH-1:0]               retire_o
);

    uop_t [RENAME_WIDTH-1:0]             uop;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0] prs1;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0] prs2;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0] prd;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0] old_prd;
    logic                                hit_rs1;
    logic                                hit_rs2;
    logic                                hit_rd;

    assign uop = head_i.uop;

    // Table ports: rs1/rs2 per slot first, then the two destinations
    always_comb begin
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            rd_areg_o[2*s]                = uop[s].rs1;
            rd_areg_o[2*s+1]              = uop[s].rs2;
            rd_areg_o[2*RENAME_WIDTH + s] = uop[s].rd;
            alloc_o[s] = uop[s].valid & uop[s].writes_rd & (uop[s].rd != '0);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Intra-bundle bypass
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign hit_rs1 = alloc_o[0] && (uop[1].rs1 == uop[0].rd);
    assign hit_rs2 = alloc_o[0] && (uop[1].rs2 == uop[0].rd);
    assign hit_rd  = alloc_o[0] && (uop[1].rd == uop[0].rd);

    assign prs1[0]    = src_preg_i[0];
    assign prs2[0]    = src_preg_i[1];
    assign old_prd[0] = src_preg_i[2*RENAME_WIDTH];

    // Slot 1 must see slot 0's fresh mapping, not the table's
    assign prs1[1]    = hit_rs1 ? new_preg_i[0] : src_preg_i[2];
    assign prs2[1]    = hit_rs2 ? new_preg_i[0] : src_preg_i[3];
    assign old_prd[1] = hit_rd ? new_preg_i[0] : src_preg_i[2*RENAME_WIDTH + 1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Packets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            prd[s] = alloc_o[s] ? new_preg_i[s] : '0;   // x0 stays on preg 0

            dispatch_o[s].valid    = uop[s].valid;
            dispatch_o[s].opcode   = uop[s].opcode;
            dispatch_o[s].prs1     = prs1[s];
            dispatch_o[s].prs2     = prs2[s];
            dispatch_o[s].prd      = prd[s];
            dispatch_o[s].uses_imm = uop[s].uses_imm;
            dispatch_o[s].imm      = uop[s].imm;
            dispatch_o[s].rob_id   = {rob_pack_i, 1'(s)};

            retire_o[s].valid     = uop[s].valid;
            retire_o[s].allocated = alloc_o[s];
            retire_o[s].arch_rd   = uop[s].rd;
            retire_o[s].old_prd   = old_prd[s];
            retire_o[s].new_prd   = prd[s];
        end
    end

endmodule

`default_nettype wire

/* logic/rename_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_top import rename_pkg::*; (
    input  wire logic                        cpu_clock_i,
    input  wire logic                        arst_n_i,
    input  wire bundle_t                     bundle_i,
    input  wire logic                        valid_i,
    output logic                             rn_busy_o,
    input  wire logic [PACK_W-1:0]           rob_pack_i,
    input  wire logic                        sched_busy_i,
    input  wire logic                        rob_busy_i,
    output dispatch_t [RENAME_WIDTH-1:0]     dispatch_o,
    output retire_t   [RENAME_WIDTH-1:0]     retire_o,
    output logic      [PC_W-1:0]             retire_pc_o,
    output logic                             retire_push_o,
    input  wire commit_t [RENAME_WIDTH-1:0]  commit_i,
    input  wire logic                        recovery_i
);

    bundle_t                                 head;
    logic                                    head_valid;
    logic                                    fire;
    logic [3*RENAME_WIDTH-1:0][AREG_W-1:0]   rd_areg;
    logic [3*RENAME_WIDTH-1:0][PREG_W-1:0]   rd_preg;
    logic [RENAME_WIDTH-1:0]                 alloc;
    logic [RENAME_WIDTH-1:0]                 pop;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0]     new_preg;
    logic [PREG_W-1:0]                       avail;
    dispatch_t [RENAME_WIDTH-1:0]            dispatch;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fire gate
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign fire = head_valid & ~(sched_busy_i | rob_busy_i)
                & (avail >= PREG_W'($countones(alloc)));
    assign pop  = alloc & {RENAME_WIDTH{fire}};   // Also the table write enables

    always_comb begin
        dispatch_o = dispatch;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            dispatch_o[s].valid = dispatch[s].valid & fire;
        end
    end

    assign retire_push_o = fire;
    assign retire_pc_o   = head.pc;

    rename_skid u_skid (
        .cpu_clock_i  (cpu_clock_i),
        .arst_n_i     (arst_n_i),
        .bundle_i     (bundle_i),
        .valid_i      (valid_i),
        .busy_o       (rn_busy_o),
        .recovery_i   (recovery_i),
        .head_o       (head),
        .head_valid_o (head_valid),
        .take_i       (fire)
    );

    spec_map_table u_map (
        .cpu_clock_i (cpu_clock_i),
        .arst_n_i    (arst_n_i),
        .rd_areg_i   (rd_areg),
        .rd_preg_o   (rd_preg),
        .wr_en_i     (pop),
        .wr_areg_i   (rd_areg[2*RENAME_WIDTH +: RENAME_WIDTH]),
        .wr_preg_i   (new_preg),
        .commit_i    (commit_i),
        .recovery_i  (recovery_i)
    );

    free_list u_free (
        .cpu_clock_i (cpu_clock_i),
        .arst_n_i    (arst_n_i),
        .pop_i       (pop),
        .pop_preg_o  (new_preg),
        .avail_o     (avail),
        .commit_i    (commit_i),
        .recovery_i  (recovery_i)
    );

    rename_bundle u_bundle (
        .head_i     (head),
        .src_preg_i (rd_preg),
        .new_preg_i (new_preg),
        .rob_pack_i (rob_pack_i),
        .rd_areg_o  (rd_areg),
        .alloc_o    (alloc),
        .dispatch_o (dispatch),
        .retire_o   (retire_o)
    );

endmodule

`default_nettype wire

/* verification/rename_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_chk import rename_pkg::*; (
    input wire logic                         cpu_clock_i,
    input wire logic                         arst_n_i,
    input wire logic                         rn_busy_i,
    input wire logic                         retire_push_i,
    input wire dispatch_t [RENAME_WIDTH-1:0] dispatch_i,
    input wire retire_t   [RENAME_WIDTH-1:0] retire_i
);

    int unsigned fail_count = 0;

    // Two allocations in one bundle never share a preg
    distinct_prd: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        (dispatch_i[0].valid && dispatch_i[1].valid
            && retire_i[0].allocated && retire_i[1].allocated)
            |-> (dispatch_i[0].prd != dispatch_i[1].prd))
        else begin
            $error("both slots allocated preg %0d", dispatch_i[0].prd);
            fail_count++;
        end

    for (genvar s = 0; s < RENAME_WIDTH; s++) begin : g_slot
        new_prd_range: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
            (retire_push_i && retire_i[s].allocated) |-> (retire_i[s].new_prd >= ARCH_REGS))
            else begin
                $error("slot %0d allocated preg %0d", s, retire_i[s].new_prd);
                fail_count++;
            end
    end

    busy_low_in_reset: assert property (@(posedge cpu_clock_i) !arst_n_i |-> !rn_busy_i)
        else begin
            $error("busy high during reset");
            fail_count++;
        end

endmodule

bind rename_top rename_chk u_chk (
    .cpu_clock_i   (cpu_clock_i),
    .arst_n_i      (arst_n_i),
    .rn_busy_i     (rn_busy_o),
    .retire_push_i (retire_push_o),
    .dispatch_i    (dispatch_o),
    .retire_i      (retire_o)
);

`default_nettype wire

/* verification/rename_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_tb import rename_pkg::*; ();

    localparam int WAIT_MAX = 40;

    logic                         cpu_clock = 1'b0;
    logic                         arst_n;
    bundle_t                      bundle;
    logic                         valid;
    logic                         rn_busy;
    logic [PACK_W-1:0]            rob_pack;
    logic                         sched_busy;
    logic                         rob_busy;
    dispatch_t [RENAME_WIDTH-1:0] dispatch;
    retire_t   [RENAME_WIDTH-1:0] retire;
    logic      [PC_W-1:0]         retire_pc;
    logic                         retire_push;
    commit_t   [RENAME_WIDTH-1:0] commit;
    logic                         recovery;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [PREG_W-1:0]          model_map  [ARCH_REGS];
    logic [PREG_W-1:0]          model_cmap [ARCH_REGS];
    logic [PREG_W-1:0]          free_q [$];   // Starts at the committed head
    int                         spec_cnt;     // Popped, not yet committed
    bundle_t                    sent_q [$];
    retire_t [RENAME_WIDTH-1:0] last_exp;
    retire_t [RENAME_WIDTH-1:0] last_act;
    integer                     seed = 29;
    string                      test_name;
    int                         test_errors;
    int                         errors = 0;
    int                         tests_run = 0;
    int                         tests_failed = 0;

    always #4 cpu_clock = ~cpu_clock;

    rename_top uut (
        .cpu_clock_i   (cpu_clock),
        .arst_n_i      (arst_n),
        .bundle_i      (bundle),
        .valid_i       (valid),
        .rn_busy_o     (rn_busy),
        .rob_pack_i    (rob_pack),
        .sched_busy_i  (sched_busy),
        .rob_busy_i    (rob_busy),
        .dispatch_o    (dispatch),
        .retire_o      (retire),
        .retire_pc_o   (retire_pc),
        .retire_push_o (retire_push),
        .commit_i      (commit),
        .recovery_i    (recovery)
    );

    function automatic uop_t make_uop(alu_op_e op, int rs1, int rs2, int rd, bit wr);
        uop_t u;
        u           = '0;
        u.valid     = 1'b1;
        u.opcode    = op;
        u.rs1       = AREG_W'(rs1);
        u.rs2       = AREG_W'(rs2);
        u.rd        = AREG_W'(rd);
        u.imm       = IMM_W'($random(seed));
        u.uses_imm  = u.imm[0];
        u.writes_rd = wr;
        return u;
    endfunction

    function automatic bundle_t make_bundle(uop_t u0, uop_t u1);
        bundle_t b;
        b.uop[0] = u0;
        b.uop[1] = u1;
        b.pc     = PC_W'($random(seed));
        return b;
    endfunction

    function automatic int rand_reg();
        return $random(seed) & (ARCH_REGS - 1);
    endfunction

    // Slots in order, so slot 1 sees slot 0's new mapping
    task automatic model_rename(input bundle_t b, input logic [PACK_W-1:0] pack,
                                output dispatch_t [RENAME_WIDTH-1:0] d,
                                output retire_t [RENAME_WIDTH-1:0] r);
        uop_t u;
        bit   alloc;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            u     = b.uop[s];
            alloc = u.valid && u.writes_rd && (u.rd != 0);
            d[s].valid     = u.valid;
            d[s].opcode    = u.opcode;
            d[s].prs1      = model_map[u.rs1];
            d[s].prs2      = model_map[u.rs2];
            d[s].prd       = alloc ? free_q[spec_cnt] : '0;
            d[s].uses_imm  = u.uses_imm;
            d[s].imm       = u.imm;
            d[s].rob_id    = {pack, 1'(s)};
            r[s].valid     = u.valid;
            r[s].allocated = alloc;
            r[s].arch_rd   = u.rd;
            r[s].old_prd   = model_map[u.rd];
            r[s].new_prd   = d[s].prd;
            if (alloc) begin
                model_map[u.rd] = d[s].prd;
                spec_cnt++;
            end
        end
    endtask

    task automatic check_dispatch(input dispatch_t exp, input dispatch_t act);
        if (act !== exp) begin
            $display("** Error %s: dispatch expected %h, actual %h", test_name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_retire(input retire_t exp, input retire_t act);
        if (act !== exp) begin
            $display("** Error %s: retire expected %h, actual %h", test_name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_pc(input logic [PC_W-1:0] exp, input logic [PC_W-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: retire pc expected %h, actual %h", test_name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_preg(input logic [PREG_W-1:0] exp, input logic [PREG_W-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: preg expected %0d, actual %0d", test_name, exp, act);
            test_errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge cpu_clock);
        arst_n <= 1'b0;
        repeat (2) @(posedge cpu_clock);
        arst_n <= 1'b1;
        for (int r = 0; r < ARCH_REGS; r++) begin
            model_map[r]  = PREG_W'(r);
            model_cmap[r] = PREG_W'(r);
        end
        free_q.delete();
        for (int i = 0; i < FREE_AT_RESET; i++) free_q.push_back(PREG_W'(ARCH_REGS + i));
        spec_cnt = 0;
        sent_q.delete();
    endtask

    // Holds the bundle on the input until the stage takes it
    task automatic send_bundle(input bundle_t b);
        int n;
        n = 0;
        @(posedge cpu_clock);
        bundle <= b;
        valid  <= 1'b1;
        @(negedge cpu_clock);
        while (rn_busy && n < WAIT_MAX) begin
            @(negedge cpu_clock);
            n++;
        end
        if (rn_busy) begin
            $display("%s: stage stayed busy for %0d cycles", test_name, WAIT_MAX);
            test_errors++;
        end else begin
            sent_q.push_back(b);
        end
        @(posedge cpu_clock);   // Accept edge
        valid <= 1'b0;
    endtask

    task automatic expect_bundle();
        dispatch_t [RENAME_WIDTH-1:0] exp_d;
        retire_t   [RENAME_WIDTH-1:0] exp_r;
        bundle_t                      b;
        int                           n;
        n = 0;
        @(negedge cpu_clock);
        while (!retire_push && n < WAIT_MAX) begin
            @(negedge cpu_clock);
            n++;
        end
        if (!retire_push || sent_q.size() == 0) begin
            $display("%s: no expected bundle left the stage in %0d cycles", test_name, WAIT_MAX);
            test_errors++;
            return;
        end
        b = sent_q.pop_front();
        model_rename(b, rob_pack, exp_d, exp_r);
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            check_dispatch(exp_d[s], dispatch[s]);
            check_retire(exp_r[s], retire[s]);
        end
        check_pc(b.pc, retire_pc);
        last_exp = exp_r;
        last_act = retire;
        @(posedge cpu_clock);   // Fire edge
    endtask

    task automatic commit_bundle(input retire_t [RENAME_WIDTH-1:0] r);
        commit_t [RENAME_WIDTH-1:0] c;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            c[s].valid     = r[s].valid;
            c[s].allocated = r[s].allocated;
            c[s].arch_rd   = r[s].arch_rd;
            c[s].new_prd   = r[s].new_prd;
            c[s].old_prd   = r[s].old_prd;
        end
        @(posedge cpu_clock);
        commit <= c;
        @(posedge cpu_clock);
        commit <= '0;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            if (c[s].valid && c[s].allocated) begin
                model_cmap[c[s].arch_rd] = c[s].new_prd;
                void'(free_q.pop_front());   // Oldest allocation commits first
                spec_cnt--;
                free_q.push_back(c[s].old_prd);
            end
        end
    endtask

    task automatic pulse_recovery();
        @(posedge cpu_clock);
        recovery <= 1'b1;
        @(posedge cpu_clock);
        recovery <= 1'b0;
        model_map = model_cmap;
        spec_cnt  = 0;
        sent_q.delete();
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, test_errors);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic basic_rename();
        begin_test("basic rename");
        rob_pack <= 4'h3;
        send_bundle(make_bundle(make_uop(ALU_ADD, 1, 2, 3, 1'b1),
                                make_uop(ALU_SUB, 4, 5, 6, 1'b1)));
        expect_bundle();
        end_test();
    endtask

    task automatic intra_bundle();
        begin_test("intra-bundle dependency");
        rob_pack <= 4'hc;
        send_bundle(make_bundle(make_uop(ALU_ADD, 1, 2, 7, 1'b1),
                                make_uop(ALU_XOR, 7, 3, 7, 1'b1)));   // Same rd twice
        expect_bundle();
        send_bundle(make_bundle(make_uop(ALU_OR, 7, 7, 10, 1'b1),
                                make_uop(ALU_AND, 10, 7, 11, 1'b1)));
        expect_bundle();
        end_test();
    endtask

    task automatic x0_write();
        begin_test("x0 write");
        rob_pack <= 4'h7;
        send_bundle(make_bundle(make_uop(ALU_AND, 3, 6, 0, 1'b1),
                                make_uop(ALU_OR, 0, 7, 12, 1'b1)));
        expect_bundle();
        send_bundle(make_bundle(make_uop(ALU_SLL, 12, 0, 5, 1'b0),
                                make_uop(ALU_SRL, 12, 5, 16, 1'b1)));
        expect_bundle();
        end_test();
    endtask

    task automatic back_pressure();
        bundle_t b [3];
        int      n;
        begin_test("back-pressure");
        for (int i = 0; i < 3; i++) begin
            b[i] = make_bundle(make_uop(ALU_XOR, rand_reg(), rand_reg(), rand_reg(), 1'b1),
                               make_uop(ALU_SLTU, rand_reg(), rand_reg(), rand_reg(), 1'b1));
        end
        rob_pack   <= 4'h9;
        sched_busy <= 1'b1;
        fork
            for (int i = 0; i < 3; i++) send_bundle(b[i]);
            begin
                n = 0;
                @(negedge cpu_clock);
                while (!rn_busy && n < WAIT_MAX) begin
                    @(negedge cpu_clock);
                    n++;
                end
                if (!rn_busy) begin
                    $display("%s: busy never rose with the scheduler stalled", test_name);
                    test_errors++;
                end
                @(posedge cpu_clock);
                sched_busy <= 1'b0;
                repeat (3) expect_bundle();
            end
        join
        end_test();
    endtask

    task automatic commit_recovery();
        retire_t [RENAME_WIDTH-1:0] first;
        retire_t [RENAME_WIDTH-1:0] second;
        begin_test("commit and recovery");
        apply_reset();
        rob_pack <= 4'h5;
        send_bundle(make_bundle(make_uop(ALU_ADD, 1, 2, 13, 1'b1),
                                make_uop(ALU_SLT, 13, 4, 14, 1'b1)));
        expect_bundle();
        first = last_exp;
        send_bundle(make_bundle(make_uop(ALU_SRA, 13, 14, 13, 1'b1),
                                make_uop(ALU_SLL, 14, 13, 14, 1'b1)));
        expect_bundle();
        second = last_exp;
        commit_bundle(first);
        pulse_recovery();
        send_bundle(make_bundle(make_uop(ALU_SRL, 13, 14, 13, 1'b1),
                                make_uop(ALU_SLTU, 14, 13, 14, 1'b1)));
        expect_bundle();
        // Wrong-path pregs come back in allocation order
        for (int s = 0; s < RENAME_WIDTH; s++) check_preg(second[s].new_prd, last_act[s].new_prd);
        end_test();
    endtask

    initial begin
        arst_n     = 1'b0;
        bundle     = '0;
        valid      = 1'b0;
        rob_pack   = '0;
        sched_busy = 1'b0;
        rob_busy   = 1'b0;
        commit     = '0;
        recovery   = 1'b0;
        apply_reset();
        basic_rename();
        intra_bundle();
        x0_write();
        back_pressure();
        commit_recovery();
        $display("%0d tests, %0d failing, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, errors, uut.u_chk.fail_count);
        if (errors == 0 && uut.u_chk.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
logic/rename_pkg.sv
logic/rename_skid.sv
logic/spec_map_table.sv
logic/free_list.sv
logic/rename_bundle.sv
logic/rename_top.sv
verification/rename_chk.sv
verification/rename_tb.sv
